//--- common/dispPkg.sv
`default_nettype none

package dispPkg;

  // clocks between two serial ticks
  localparam int TICK_DIV = 4;

  // digits on the display, one per nibble of the value
  localparam int NUM_DIGITS = 4;

  // bits in one frame for the two chained 595s
  localparam int FRAME_BITS = 16;

  // credits the upstream holds after reset
  localparam int VALUE_CREDITS = 1;

  // width of the tick divider counter
  localparam int TICK_CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

  // width of the serializer bit counter
  localparam int BIT_CNT_W = $clog2(FRAME_BITS);

  // display value, digit n is nibble n
  typedef logic [4*NUM_DIGITS-1:0] hexValue_t;

  // one decimal point enable per digit
  typedef logic [NUM_DIGITS-1:0] dpMask_t;

  // segments g down to a, a 1 lights the segment
  typedef logic [6:0] segments_t;

  // digit index
  typedef logic [$clog2(NUM_DIGITS)-1:0] digitSel_t;

  // 595 frame
  // bit 15 dp, bits 14..8 segments, bits 7..4 zero, bits 3..0 one-hot select
  typedef logic [FRAME_BITS-1:0] frame_t;

  // serializer states
  typedef enum logic [1:0] {
    IDLE,
    SHIFT,
    LATCH
  } serState_t;

endpackage

`default_nettype wire

//--- dispDriverTop.f
common/dispPkg.sv
verilog/tickGen.sv
shift595/frameBuilder.sv
shift595/shiftOut595.sv
verilog/dispDriverTop.sv
tb/dispDriver_assert.sv
tb/dispDriverTb.sv

//--- runSim.sh
#!/bin/sh
# build and run the display driver testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module dispDriverTb \
  -f dispDriverTop.f \
  -o dispDriverSim &&
  ./obj_dir/dispDriverSim || {
    echo "simulation did not pass"
    exit 1
  }

//--- shift595/frameBuilder.sv
`timescale 1ns/100ps
`default_nettype none

module frameBuilder (
  input  wire                     CLK,
  input  wire                     reset,
  input  wire                     valueValid,
  input  wire dispPkg::hexValue_t value,
  input  wire dispPkg::dpMask_t   dpMask,
  input  wire                     frameTake,
  output dispPkg::frame_t         frame,
  output logic                    creditReturn
);

  import dispPkg::*;

  // digit of the frame currently presented
  digitSel_t digit;

  // value on the display
  hexValue_t shownValue;
  dpMask_t   shownMask;

  // word waiting for the next digit 0 frame, holds the single credit
  hexValue_t pendValue;
  dpMask_t   pendMask;
  logic      pendFull;

  // pending word takes over at the start of a refresh round
  logic      promoteReady;
  hexValue_t useValue;
  dpMask_t   useMask;
  segments_t segs;
  logic [NUM_DIGITS-1:0] digitOneHot;

  // hex nibble to segments g..a
  function automatic segments_t hexToSeg(input logic [3:0] nibble);
    case (nibble)
      4'h0: hexToSeg = 7'b0111111;
      4'h1: hexToSeg = 7'b0000110;
      4'h2: hexToSeg = 7'b1011011;
      4'h3: hexToSeg = 7'b1001111;
      4'h4: hexToSeg = 7'b1100110;
      4'h5: hexToSeg = 7'b1101101;
      4'h6: hexToSeg = 7'b1111101;
      4'h7: hexToSeg = 7'b0000111;
      4'h8: hexToSeg = 7'b1111111;
      4'h9: hexToSeg = 7'b1101111;
      4'hA: hexToSeg = 7'b1110111;
      4'hB: hexToSeg = 7'b1111100;
      4'hC: hexToSeg = 7'b0111001;
      4'hD: hexToSeg = 7'b1011110;
      4'hE: hexToSeg = 7'b1111001;
      default: hexToSeg = 7'b1110001;
    endcase
  endfunction

  // the digit 0 frame already shows the pending word, so the promoted
  // value applies to the frame taken in the promoting clock
  assign promoteReady = (digit == '0) && pendFull;
  assign useValue     = promoteReady ? pendValue : shownValue;
  assign useMask      = promoteReady ? pendMask : shownMask;

  // credit goes back in the same clock as the promotion
  assign creditReturn = frameTake && promoteReady;

  always_comb begin
    segs = hexToSeg(useValue[4*digit +: 4]);
    digitOneHot = '0;
    digitOneHot[digit] = 1'b1;
    // unused middle bits stay zero
    frame = '0;
    frame[FRAME_BITS-1] = useMask[digit];
    frame[FRAME_BITS-2 -: $bits(segments_t)] = segs;
    frame[NUM_DIGITS-1:0] = digitOneHot;
  end

  // digit counter and display state
  always_ff @(posedge CLK) begin
    if (reset) begin
      digit      <= '0;
      shownValue <= '0;
      shownMask  <= '0;
      pendFull   <= 1'b0;
    end else begin
      if (frameTake) begin
        if (digit == digitSel_t'(NUM_DIGITS - 1)) begin
          digit <= '0;
        end else begin
          digit <= digit + 1'b1;
        end
      end
      if (creditReturn) begin
        shownValue <= pendValue;
        shownMask  <= pendMask;
        pendFull   <= 1'b0;
      end
      // a new word wins over the clear above
      if (valueValid) begin
        pendFull <= 1'b1;
      end
    end
  end

  // pending payload
  always_ff @(posedge CLK) begin
    if (valueValid) begin
      pendValue <= value;
      pendMask  <= dpMask;
    end
  end

endmodule

`default_nettype wire

//--- shift595/shiftOut595.sv
`timescale 1ns/100ps
`default_nettype none

module shiftOut595 (
  input  wire                  CLK,
  input  wire                  reset,
  input  wire                  tick,
  input  wire dispPkg::frame_t frame,
  output logic                 frameTake,
  output logic                 SCK,
  output logic                 DO,
  output logic                 LATCH
);

  import dispPkg::*;

  serState_t state;

  // bits still to go, msb is the next one on DO
  frame_t shiftReg;

  // index of the bit now on DO
  logic [BIT_CNT_W-1:0] bitCnt;

  // 0 while SCK is low, 1 after the shift edge
  logic sckPhase;

  logic lastBit;
  logic shiftNext;

  assign SCK = sckPhase;

  // a frame is taken on the tick that leaves IDLE or ends the latch interval
  assign frameTake = tick && (state != SHIFT);

  assign lastBit = (bitCnt == BIT_CNT_W'(FRAME_BITS - 1));

  // falling tick with more bits left
  assign shiftNext = tick && (state == SHIFT) && sckPhase && !lastBit;

  // control and pin state
  always_ff @(posedge CLK) begin
    if (reset) begin
      state    <= IDLE;
      sckPhase <= 1'b0;
      DO       <= 1'b0;
      LATCH    <= 1'b0;
      bitCnt   <= '0;
    end else if (tick) begin
      case (state)
        IDLE, dispPkg::LATCH: begin
          // this tick is also the low half of the first bit
          DO       <= frame[FRAME_BITS-1];
          bitCnt   <= '0;
          LATCH    <= 1'b0;
          sckPhase <= 1'b0;
          state    <= SHIFT;
        end
        SHIFT: begin
          if (!sckPhase) begin
            // rising SCK, the 595 samples DO here
            sckPhase <= 1'b1;
          end else begin
            sckPhase <= 1'b0;
            if (lastBit) begin
              // SCK drops and LATCH rises together, DO holds
              LATCH <= 1'b1;
              state <= dispPkg::LATCH;
            end else begin
              DO     <= shiftReg[FRAME_BITS-1];
              bitCnt <= bitCnt + 1'b1;
            end
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // shift register payload
  always_ff @(posedge CLK) begin
    if (frameTake) begin
      // msb already went to DO
      shiftReg <= frame << 1;
    end else if (shiftNext) begin
      shiftReg <= shiftReg << 1;
    end
  end

endmodule

`default_nettype wire

//--- tb/dispDriverTb.sv
`timescale 1ns/100ps
`default_nettype none

module dispDriverTb;

  import dispPkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_ENTRIES = 10;
  localparam int NUM_FIXED = 6;
  // one frame is 33 ticks
  localparam int FRAME_CLKS = 33 * TICK_DIV;
  // five frames per entry, doubled, plus the reset time
  localparam int WATCHDOG_NS =
    NUM_ENTRIES * 5 * FRAME_CLKS * CLK_PERIOD * 2 + RESET_CYCLES * CLK_PERIOD;

  logic      CLK = 1'b0;
  logic      reset;
  logic      valueValid;
  hexValue_t value;
  dpMask_t   dpMask;
  logic      creditReturn;
  logic      SCK;
  logic      DO;
  logic      LATCH;

  // stimulus table
  hexValue_t tblValue [NUM_ENTRIES];
  dpMask_t   tblMask  [NUM_ENTRIES];

  // reference segment patterns g..a, indexed by nibble
  segments_t segTable [16];

  // frames seen on the pins, in latch order
  frame_t frameQ [$];
  // number of latched frames at each creditReturn
  int     crFrameIdx [$];
  int     creditCount;
  int     sentCount;
  // number of latched frames when the last word went out
  int     sendFrameCnt;

  dispDriverTop dut (
    .CLK          (CLK),
    .reset        (reset),
    .valueValid   (valueValid),
    .value        (value),
    .dpMask       (dpMask),
    .creditReturn (creditReturn),
    .SCK          (SCK),
    .DO           (DO),
    .LATCH        (LATCH)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  // shift in DO on each SCK rise, hand the frame over on each LATCH rise
  always @(posedge CLK) begin
    frame_t capFrame;
    logic   sckPrev;
    logic   latchPrev;
    if (reset) begin
      capFrame    = '0;
      sckPrev     = 1'b0;
      latchPrev   = 1'b0;
      creditCount = 0;
    end else begin
      if (SCK && !sckPrev) begin
        capFrame = {capFrame[FRAME_BITS-2:0], DO};
      end
      if (LATCH && !latchPrev) begin
        frameQ.push_back(capFrame);
      end
      if (creditReturn) begin
        creditCount++;
        crFrameIdx.push_back(frameQ.size());
      end
      sckPrev   = SCK;
      latchPrev = LATCH;
    end
  end

  task automatic stopRun();
    $display("=== FAIL ===");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic checkFrame(input string name, input frame_t exp, input frame_t act);
    if (act !== exp) begin
      $display("ERR %s expected %b actual %b", name, exp, act);
      stopRun();
    end
  endtask

  task automatic checkCredit(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("ERR %s expected %0d actual %0d", name, exp, act);
      stopRun();
    end
  endtask

  task automatic checkPin(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %s expected %b actual %b", name, exp, act);
      stopRun();
    end
  endtask

  // credits the upstream holds right now
  function automatic int heldCredits();
    return VALUE_CREDITS - sentCount + creditCount;
  endfunction

  // expected 595 frame for one digit
  function automatic frame_t expFrame(input hexValue_t v, input dpMask_t m, input int d);
    frame_t f;
    f = '0;
    f[FRAME_BITS-1] = m[d];
    f[FRAME_BITS-2 -: 7] = segTable[v[4*d +: 4]];
    // one-hot select sits in the low nibble
    f[d] = 1'b1;
    return f;
  endfunction

  task automatic buildTable();
    logic [31:0] rnd;
    segTable = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
                 7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};
    // first four cover all sixteen nibbles
    tblValue[0] = 16'h3210;
    tblMask[0]  = 4'b0001;
    tblValue[1] = 16'h7654;
    tblMask[1]  = 4'b1010;
    tblValue[2] = 16'hBA98;
    tblMask[2]  = 4'b1111;
    tblValue[3] = 16'hFEDC;
    tblMask[3]  = 4'b0000;
    tblValue[4] = 16'h0000;
    tblMask[4]  = 4'b1000;
    tblValue[5] = 16'hA5C3;
    tblMask[5]  = 4'b0110;
    for (int i = NUM_FIXED; i < NUM_ENTRIES; i++) begin
      rnd = $urandom;
      tblValue[i] = rnd[15:0];
      tblMask[i]  = rnd[19:16];
    end
  endtask

  // one-clock valueValid, only while the credit is held
  task automatic sendEntry(input int idx);
    while (heldCredits() < 1) begin
      @(posedge CLK);
    end
    sendFrameCnt = frameQ.size();
    @(posedge CLK);
    valueValid <= 1'b1;
    value      <= tblValue[idx];
    dpMask     <= tblMask[idx];
    sentCount++;
    @(posedge CLK);
    valueValid <= 1'b0;
  endtask

  task automatic waitFrames(input int n);
    while (frameQ.size() < n) begin
      @(posedge CLK);
    end
  endtask

  task automatic waitCredits(input int n);
    while (creditCount < n) begin
      @(posedge CLK);
    end
  endtask

  initial begin
    int cnt;
    int d;
    int startIdx;
    reset      = 1'b1;
    valueValid = 1'b0;
    value      = '0;
    dpMask     = '0;
    sentCount  = 0;
    sendFrameCnt = 0;
    void'($urandom(2));
    buildTable();
    repeat (RESET_CYCLES) @(posedge CLK);
    reset <= 1'b0;
    @(posedge CLK);
    checkPin("SCK after reset", 1'b0, SCK);
    checkPin("DO after reset", 1'b0, DO);
    checkPin("LATCH after reset", 1'b0, LATCH);
    checkPin("creditReturn after reset", 1'b0, creditReturn);
    // one tick of slack for reset release and capture
    cnt = 0;
    while (frameQ.size() == 0) begin
      if (cnt > (34 + 1) * TICK_DIV) begin
        $display("no LATCH pulse came within 34 ticks of reset release");
        stopRun();
      end
      @(posedge CLK);
      cnt++;
    end
    // display shows zeros with every dp off
    waitFrames(NUM_DIGITS);
    for (d = 0; d < NUM_DIGITS; d++) begin
      checkFrame($sformatf("reset digit %0d", d), expFrame('0, '0, d), frameQ[d]);
    end
    checkCredit("credit after reset", VALUE_CREDITS, heldCredits());
    sendEntry(0);
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      waitCredits(i + 1);
      startIdx = crFrameIdx[i];
      // promotion comes at the first digit 0 frame after the send
      if (startIdx - sendFrameCnt > NUM_DIGITS) begin
        $display("credit for entry %0d came back more than one round after the send", i);
        stopRun();
      end
      // next word goes out mid-frame and must wait for the next round
      if (i + 1 < NUM_ENTRIES) begin
        sendEntry(i + 1);
      end
      waitFrames(startIdx + NUM_DIGITS);
      for (d = 0; d < NUM_DIGITS; d++) begin
        checkFrame($sformatf("entry %0d digit %0d", i, d),
                   expFrame(tblValue[i], tblMask[i], d), frameQ[startIdx + d]);
      end
      checkCredit($sformatf("no early credit after entry %0d", i), i + 1, creditCount);
    end
    // one more refresh round with nothing pending
    waitFrames(frameQ.size() + NUM_DIGITS);
    checkCredit("creditReturn pulses", sentCount, creditCount);
    $display("=== PASS ===");
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("timeout after %0d ns, the DUT stopped making progress", WATCHDOG_NS);
    stopRun();
  end

endmodule

`default_nettype wire

//--- tb/dispDriver_assert.sv
`timescale 1ns/100ps
`default_nettype none

module dispDriverAssert (
  input wire CLK,
  input wire reset,
  input wire valueValid,
  input wire creditReturn,
  input wire SCK,
  input wire DO,
  input wire LATCH
);

  import dispPkg::*;

  // credits on the upstream side, mirrored from the handshake
  int upCredits;

  always_ff @(posedge CLK) begin
    if (reset) begin
      upCredits <= VALUE_CREDITS;
    end else begin
      upCredits <= upCredits - int'(valueValid) + int'(creditReturn);
    end
  end

  // storage register only latches with the shift clock low
  latchSckLow: assert property (@(posedge CLK) disable iff (reset) !(LATCH && SCK))
    else $error("LATCH high while SCK high");

  // data must hold across the 595 shift edge
  doStable: assert property (@(posedge CLK) disable iff (reset) SCK |-> $stable(DO))
    else $error("DO changed while SCK high");

  // a word may only go out while a credit is held
  creditHeld: assert property (@(posedge CLK) disable iff (reset)
    valueValid |-> (upCredits > 0))
    else $error("valueValid without a credit");

endmodule

bind dispDriverTop dispDriverAssert uAssert (
  .CLK          (CLK),
  .reset        (reset),
  .valueValid   (valueValid),
  .creditReturn (creditReturn),
  .SCK          (SCK),
  .DO           (DO),
  .LATCH        (LATCH)
);

`default_nettype wire

//--- verilog/dispDriverTop.sv
`timescale 1ns/100ps
`default_nettype none

module dispDriverTop (
  input  wire                     CLK,
  input  wire                     reset,
  input  wire                     valueValid,
  input  wire dispPkg::hexValue_t value,
  input  wire dispPkg::dpMask_t   dpMask,
  output logic                    creditReturn,
  output logic                    SCK,
  output logic                    DO,
  output logic                    LATCH
);

  import dispPkg::*;

  // serial bit rate strobe
  logic tick;

  // serializer asks for the next frame
  logic frameTake;

  // frame for the current digit, always valid
  frame_t frame;

  tickGen uTickGen (
    .CLK   (CLK),
    .reset (reset),
    .tick  (tick)
  );

  // value register, credit and segment lookup
  frameBuilder uFrameBuilder (
    .CLK          (CLK),
    .reset        (reset),
    .valueValid   (valueValid),
    .value        (value),
    .dpMask       (dpMask),
    .frameTake    (frameTake),
    .frame        (frame),
    .creditReturn (creditReturn)
  );

  // pins to the two chained 595s
  shiftOut595 uShiftOut595 (
    .CLK       (CLK),
    .reset     (reset),
    .tick      (tick),
    .frame     (frame),
    .frameTake (frameTake),
    .SCK       (SCK),
    .DO        (DO),
    .LATCH     (LATCH)
  );

endmodule

`default_nettype wire

//--- verilog/tickGen.sv
`timescale 1ns/100ps
`default_nettype none

module tickGen (
  input  wire  CLK,
  input  wire  reset,
  output logic tick
);

  import dispPkg::*;

  // free-running divider count
  logic [TICK_CNT_W-1:0] divCnt;

  always_ff @(posedge CLK) begin
    if (reset) begin
      divCnt <= '0;
      tick   <= 1'b0;
    end else begin
      // wrap at TICK_DIV, tick is registered so it lands one clock after the wrap value
      if (divCnt == TICK_CNT_W'(TICK_DIV - 1)) begin
        divCnt <= '0;
      end else begin
        divCnt <= divCnt + 1'b1;
      end
      // one clock high per divider period
      tick <= (divCnt == TICK_CNT_W'(TICK_DIV - 1));
    end
  end

endmodule

`default_nettype wire
